// ==== tx_frame_pkg.sv ====
package tx_frame_pkg;

    // 8b10b control characters carried with the K flag set
    localparam logic [7:0] k28_5_c       = 8'hBC; // comma, event lane
    localparam logic [7:0] k28_2_start_c = 8'h5C; // opens a segment frame
    localparam logic [7:0] k28_1_stop_c  = 8'h3C; // closes the segment payload

    localparam logic [7:0] beacon_c = 8'h7E; // event code, goes out as data char

    localparam int comma_period_c  = 4; // comma on every 4th word
    localparam int beacon_period_c = 7; // beacon on remaining multiples of 7

    localparam int frame_words_def_c = 64; // words per frame, power of two
    localparam int seg_bytes_def_c   = 16; // payload bytes per segment

    // the data lane interleaves dbus bytes (even words) with frame slots
    // (odd words), so a frame has frame_words/2 slots for the segment
    //
    // slot layout
    //   0                 start
    //   1                 segment address
    //   2 .. seg_bytes+1  payload
    //   seg_bytes+2       stop
    //   seg_bytes+3       checksum high
    //   seg_bytes+4       checksum low
    //   rest              zero padding
    //
    // checksum is 0xffff minus the 16 bit sum of address and payload bytes

    typedef enum logic [2:0] {
        fld_dbus,    // even word, distributed bus byte
        fld_start,   // k28.2
        fld_addr,    // active segment number
        fld_data,    // payload byte from the active buffer
        fld_stop,    // k28.1
        fld_csum_hi, // complemented sum, msb first
        fld_csum_lo,
        fld_pad      // zero fill to the end of the frame
    } seg_field_e;

endpackage

// ==== event_lane_gen.sv ====
module event_lane_gen #(
    parameter int FRAME_WORDS = tx_frame_pkg::frame_words_def_c
) (
    input  logic                           tx_clk,
    input  logic                           arst_n_i,
    input  logic                           ready_i,      // link up level
    output logic [$clog2(FRAME_WORDS)-1:0] word_idx_o,   // index of next word out
    output logic                           frame_wrap_o, // next edge sends last word
    output logic [7:0]                     ev_byte_o,
    output logic                           ev_k_o
);

    import tx_frame_pkg::*;

    localparam int IDX_W = $clog2(FRAME_WORDS);

    logic [IDX_W-1:0] cnt_q;     // word counter wrapping at the frame length
    logic             is_comma;  // next word carries the comma
    logic             is_beacon; // next word carries the beacon

    assign is_comma  = (cnt_q % comma_period_c) == 0;
    assign is_beacon = (cnt_q % beacon_period_c) == 0; // comma has priority

    // counter sits at 0 while the link is down, so the first ready edge
    // sends word 0 and moves on to 1
    always_ff @(posedge tx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q     <= '0;
            ev_byte_o <= 8'h00;
            ev_k_o    <= 1'b0;
        end else if (!ready_i) begin
            cnt_q     <= '0;    // restart frame on next ready
            ev_byte_o <= 8'h00; // idle lane while down
            ev_k_o    <= 1'b0;
        end else begin
            cnt_q <= cnt_q + 1'b1; // mod FRAME_WORDS
            if (is_comma) begin
                ev_byte_o <= k28_5_c;
                ev_k_o    <= 1'b1;
            end else if (is_beacon) begin
                ev_byte_o <= beacon_c; // sent as a data char without K
                ev_k_o    <= 1'b0;
            end else begin
                ev_byte_o <= 8'h00;
                ev_k_o    <= 1'b0;
            end
        end
    end

    assign word_idx_o = cnt_q;

    // high in the cycle whose edge sends the last word and swaps the buffer
    assign frame_wrap_o = ready_i && (cnt_q == IDX_W'(FRAME_WORDS - 1));

    // K on the event lane only ever flags the comma byte
    comma_k_a : assert property (
        @(posedge tx_clk) disable iff (!arst_n_i)
        ev_k_o |-> (ev_byte_o == k28_5_c)
    ) else $error("event lane K on a byte other than the comma");

endmodule

// ==== segment_buffer.sv ====
module segment_buffer #(
    parameter int SEG_BYTES = tx_frame_pkg::seg_bytes_def_c
) (
    input  logic       tx_clk,
    input  logic       arst_n_i,
    input  logic       ready_i,       // link up level
    input  logic       frame_wrap_i,  // last word of frame goes out next edge
    input  logic       seg_byte_wr_i, // write strobe for a payload byte
    input  logic       seg_num_wr_i,  // write strobe for the segment number
    input  logic [7:0] seg_waddr_i,   // payload byte index
    input  logic [7:0] seg_data_i,
    input  logic [7:0] rd_slot_i,     // payload index from the framer
    output logic [7:0] rd_byte_o,
    output logic [7:0] active_num_o
);

    // index width into the arrays, at least one bit
    localparam int AW = (SEG_BYTES > 1) ? $clog2(SEG_BYTES) : 1;

    logic [7:0]    stg_mem [SEG_BYTES]; // user side, next frame
    logic [7:0]    act_mem [SEG_BYTES]; // framer side, frame in flight
    logic [7:0]    stg_num_q;           // staged segment address
    logic [7:0]    act_num_q;           // address sent in current frame
    logic          load_act;            // staging -> active this edge
    logic          wr_ok;               // byte write inside the array
    logic          rd_ok;               // read index inside the array
    logic [AW-1:0] wr_idx;
    logic [AW-1:0] rd_idx;

    // swap at the frame boundary, and keep tracking staging while down
    // so a restart sends the latest segment
    assign load_act = frame_wrap_i || !ready_i;

    assign wr_ok  = seg_byte_wr_i && (seg_waddr_i < SEG_BYTES);
    assign rd_ok  = rd_slot_i < SEG_BYTES;
    assign wr_idx = seg_waddr_i[AW-1:0];
    assign rd_idx = rd_slot_i[AW-1:0];

    always_ff @(posedge tx_clk) begin
        if (wr_ok) begin
            stg_mem[wr_idx] <= seg_data_i;
        end
        if (load_act) begin
            act_mem <= stg_mem; // takes staging before this edge's write
        end
    end

    always_ff @(posedge tx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stg_num_q <= 8'h00;
            act_num_q <= 8'h00;
        end else begin
            if (seg_num_wr_i) begin
                stg_num_q <= seg_data_i;
            end
            if (load_act) begin
                act_num_q <= stg_num_q; // same swap as the payload
            end
        end
    end

    // combinational read, the framer registers the byte
    assign rd_byte_o    = rd_ok ? act_mem[rd_idx] : 8'h00;
    assign active_num_o = act_num_q;

    waddr_range_a : assert property (
        @(posedge tx_clk) disable iff (!arst_n_i)
        seg_byte_wr_i |-> (seg_waddr_i < SEG_BYTES)
    ) else $error("segment byte write beyond SEG_BYTES");

endmodule

// ==== segment_framer.sv ====
module segment_framer #(
    parameter int FRAME_WORDS = tx_frame_pkg::frame_words_def_c,
    parameter int SEG_BYTES   = tx_frame_pkg::seg_bytes_def_c
) (
    input  logic                           tx_clk,
    input  logic                           arst_n_i,
    input  logic                           ready_i,      // link up level
    input  logic [$clog2(FRAME_WORDS)-1:0] word_idx_i,   // index of next word out
    input  logic [7:0]                     dbus_i,       // distributed bus byte
    input  logic [7:0]                     rd_byte_i,    // payload byte at rd_slot_o
    input  logic [7:0]                     active_num_i, // segment address in flight
    output logic [7:0]                     rd_slot_o,    // payload index to the buffer
    output logic [7:0]                     data_byte_o,
    output logic                           data_k_o
);

    import tx_frame_pkg::*;

    localparam int IDX_W  = $clog2(FRAME_WORDS);
    localparam int SLOT_W = IDX_W - 1; // FRAME_WORDS/2 slots per frame

    logic [SLOT_W-1:0] slot;     // data-lane slot of the next word
    seg_field_e        fld;      // what the next word carries
    logic [15:0]       csum_q;   // running sum of address and payload
    logic [7:0]        nxt_byte; // data lane before the output register
    logic              nxt_k;

    assign slot = word_idx_i[IDX_W-1:1];

    // payload starts at slot 2, slots 0 and 1 give junk that goes unused
    assign rd_slot_o = 8'(slot - SLOT_W'(2));

    always_comb begin
        if (!word_idx_i[0]) begin
            fld = fld_dbus; // even words belong to the bus
        end else if (slot == 0) begin
            fld = fld_start;
        end else if (slot == 1) begin
            fld = fld_addr;
        end else if (slot <= SEG_BYTES + 1) begin
            fld = fld_data;
        end else if (slot == SEG_BYTES + 2) begin
            fld = fld_stop;
        end else if (slot == SEG_BYTES + 3) begin
            fld = fld_csum_hi;
        end else if (slot == SEG_BYTES + 4) begin
            fld = fld_csum_lo;
        end else begin
            fld = fld_pad;
        end
    end

    always_comb begin
        nxt_byte = 8'h00;
        nxt_k    = 1'b0;
        case (fld)
            fld_dbus: begin
                nxt_byte = dbus_i; // sampled at the sending edge
            end
            fld_start: begin
                nxt_byte = k28_2_start_c;
                nxt_k    = 1'b1;
            end
            fld_addr: begin
                nxt_byte = active_num_i;
            end
            fld_data: begin
                nxt_byte = rd_byte_i;
            end
            fld_stop: begin
                nxt_byte = k28_1_stop_c;
                nxt_k    = 1'b1;
            end
            fld_csum_hi: begin
                nxt_byte = ~csum_q[15:8]; // 0xffff - sum, high first
            end
            fld_csum_lo: begin
                nxt_byte = ~csum_q[7:0];
            end
            default: begin
                nxt_byte = 8'h00; // padding
            end
        endcase
    end

    // the last payload add lands on the edge before stop, so the sum is
    // complete by the time the checksum slots are selected
    always_ff @(posedge tx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_byte_o <= 8'h00;
            data_k_o    <= 1'b0;
            csum_q      <= 16'h0000;
        end else if (!ready_i) begin
            data_byte_o <= 8'h00; // idle lane while down
            data_k_o    <= 1'b0;
        end else begin
            data_byte_o <= nxt_byte;
            data_k_o    <= nxt_k;
            case (fld)
                fld_start: csum_q <= 16'h0000; // new frame
                fld_addr:  csum_q <= csum_q + {8'h00, active_num_i};
                fld_data:  csum_q <= csum_q + {8'h00, rd_byte_i};
                default:   csum_q <= csum_q;
            endcase
        end
    end

    // a payload or checksum byte that happens to match a K code must
    // still leave as data on the following edge
    payload_no_k_a : assert property (
        @(posedge tx_clk) disable iff (!arst_n_i)
        (ready_i && (fld inside {fld_data, fld_csum_hi, fld_csum_lo})) |=> !data_k_o
    ) else $error("K flag set on a payload or checksum byte");

endmodule

// ==== tx_frame_gen.sv ====
module tx_frame_gen #(
    parameter int FRAME_WORDS = tx_frame_pkg::frame_words_def_c,
    parameter int SEG_BYTES   = tx_frame_pkg::seg_bytes_def_c
) (
    input  logic        tx_clk,
    input  logic        arst_n_i,
    input  logic        ready_i,       // tx reset done from the transceiver
    input  logic [7:0]  dbus_i,        // distributed bus byte
    input  logic        seg_byte_wr_i, // staging payload write
    input  logic        seg_num_wr_i,  // staging segment number write
    input  logic [7:0]  seg_waddr_i,
    input  logic [7:0]  seg_data_i,
    output logic [15:0] tx_data_o,     // event lane high, data lane low
    output logic [1:0]  tx_is_k_o      // K flags in the same lane order
);

    localparam int IDX_W = $clog2(FRAME_WORDS);

    logic [IDX_W-1:0] word_idx;   // index of the next word out
    logic             frame_wrap; // buffer swap point
    logic [7:0]       rd_slot;
    logic [7:0]       rd_byte;
    logic [7:0]       active_num;
    logic [7:0]       ev_byte;
    logic             ev_k;
    logic [7:0]       data_byte;
    logic             data_k;

    // frame must be a power of two and hold the whole segment frame
    if (((FRAME_WORDS & (FRAME_WORDS - 1)) != 0) || (SEG_BYTES + 5 > FRAME_WORDS / 2))
    begin : g_size_check
        $error("FRAME_WORDS or SEG_BYTES out of range");
    end

    event_lane_gen #(.FRAME_WORDS(FRAME_WORDS)) event_lane_gen_i (
        .tx_clk       (tx_clk),
        .arst_n_i     (arst_n_i),
        .ready_i      (ready_i),
        .word_idx_o   (word_idx),
        .frame_wrap_o (frame_wrap),
        .ev_byte_o    (ev_byte),
        .ev_k_o       (ev_k)
    );

    segment_buffer #(.SEG_BYTES(SEG_BYTES)) segment_buffer_i (
        .tx_clk        (tx_clk),
        .arst_n_i      (arst_n_i),
        .ready_i       (ready_i),
        .frame_wrap_i  (frame_wrap),
        .seg_byte_wr_i (seg_byte_wr_i),
        .seg_num_wr_i  (seg_num_wr_i),
        .seg_waddr_i   (seg_waddr_i),
        .seg_data_i    (seg_data_i),
        .rd_slot_i     (rd_slot),
        .rd_byte_o     (rd_byte),
        .active_num_o  (active_num)
    );

    segment_framer #(.FRAME_WORDS(FRAME_WORDS), .SEG_BYTES(SEG_BYTES)) segment_framer_i (
        .tx_clk       (tx_clk),
        .arst_n_i     (arst_n_i),
        .ready_i      (ready_i),
        .word_idx_i   (word_idx),
        .dbus_i       (dbus_i),
        .rd_byte_i    (rd_byte),
        .active_num_i (active_num),
        .rd_slot_o    (rd_slot),
        .data_byte_o  (data_byte),
        .data_k_o     (data_k)
    );

    assign tx_data_o = {ev_byte, data_byte}; // both lanes registered
    assign tx_is_k_o = {ev_k, data_k};

endmodule

// ==== tb_tx_frame_gen.sv ====
module tb_tx_frame_gen;

    import tx_frame_pkg::*;

    localparam int FRAME_WORDS = frame_words_def_c;
    localparam int SEG_BYTES   = seg_bytes_def_c;
    localparam int n_entries   = 3;
    localparam int lfsr_seed_c = 83653;
    localparam int edge_limit  = 200; // time units, two clock periods

    localparam logic [7:0] comma_code  = 8'hBC; // k28.5
    localparam logic [7:0] start_code  = 8'h5C; // k28.2
    localparam logic [7:0] stop_code   = 8'h3C; // k28.1
    localparam logic [7:0] beacon_code = 8'h7E;

    logic        tx_clk = 1'b0;
    logic        arst_n_i;
    logic        ready_i;
    logic [7:0]  dbus_i;
    logic        seg_byte_wr_i;
    logic        seg_num_wr_i;
    logic [7:0]  seg_waddr_i;
    logic [7:0]  seg_data_i;
    logic [15:0] tx_data_o;
    logic [1:0]  tx_is_k_o;

    // stimulus table, one segment per entry
    logic [7:0]  tbl_num  [n_entries];
    logic [7:0]  tbl_data [n_entries][SEG_BYTES];
    logic [15:0] tbl_csum [n_entries]; // worked out by hand

    // reference model state
    logic [7:0]  stg_num = 8'h00;
    logic [7:0]  act_num = 8'h00;
    logic [7:0]  stg_mem [SEG_BYTES];
    logic [7:0]  act_mem [SEG_BYTES];
    int          widx = 0;           // index of the next word out
    logic [15:0] exp_data;
    logic [1:0]  exp_k;
    logic        pend = 1'b0;        // a word is waiting to be checked
    logic [31:0] lfsr = lfsr_seed_c;
    logic        abort = 1'b0;       // set on a timeout
    int          n_checks = 0;
    int          n_errors = 0;

    always #50 tx_clk = ~tx_clk; // period 100

    tx_frame_gen #(.FRAME_WORDS(FRAME_WORDS), .SEG_BYTES(SEG_BYTES)) tx_frame_gen_i (
        .tx_clk        (tx_clk),
        .arst_n_i      (arst_n_i),
        .ready_i       (ready_i),
        .dbus_i        (dbus_i),
        .seg_byte_wr_i (seg_byte_wr_i),
        .seg_num_wr_i  (seg_num_wr_i),
        .seg_waddr_i   (seg_waddr_i),
        .seg_data_i    (seg_data_i),
        .tx_data_o     (tx_data_o),
        .tx_is_k_o     (tx_is_k_o)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // galois, right shift
    endfunction

    // 0xffff minus the 16 bit sum of address and payload
    function automatic logic [15:0] rule_csum(input logic [7:0] num,
                                              input logic [7:0] b [SEG_BYTES]);
        logic [15:0] sum;
        int          i;
        sum = {8'h00, num};
        for (i = 0; i < SEG_BYTES; i++) begin
            sum = sum + {8'h00, b[i]};
        end
        rule_csum = 16'hFFFF - sum;
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        int i;
        b = 8'h00;
        for (i = 0; i < 8; i++) begin
            b    = {b[6:0], lfsr[0]}; // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // polls for the next falling clock edge, gives up after edge_limit
    task automatic wait_fall();
        logic prev;
        logic found;
        int   n;
        found = 1'b0;
        if (!abort) begin
            for (n = 0; n < edge_limit && !found; n++) begin
                prev = tx_clk;
                #1;
                found = (prev === 1'b1) && (tx_clk === 1'b0);
            end
            if (!found) begin
                $display("timeout: no falling clock edge within %0d time units", edge_limit);
                abort = 1'b1;
            end
        end
    endtask

    task automatic fill_table();
        int i;
        for (i = 0; i < SEG_BYTES; i++) begin
            tbl_data[0][i] = 8'h00;
            tbl_data[1][i] = 8'(i + 1);
            tbl_data[2][i] = 8'hBC; // comma look-alike as payload
        end
        tbl_num[0]     = 8'hFF; // reference segment
        tbl_data[0][1] = 8'h8B;
        tbl_data[0][2] = 8'hFC;
        tbl_data[0][3] = 8'h7B;
        tbl_data[0][7] = 8'h07;
        tbl_data[0][15] = 8'h07;
        tbl_csum[0]    = 16'hFCF0;
        tbl_num[1]     = 8'h01;
        tbl_csum[1]    = 16'hFF76;
        tbl_num[2]     = 8'h3C; // stop look-alike as address
        tbl_csum[2]    = 16'hF403;
    endtask

    // one word: check the last one, drive inputs, predict the next one
    task automatic step(input logic rdy, input logic wr_num, input logic wr_byte,
                        input logic [7:0] waddr, input logic [7:0] wdata);
        logic [7:0]  db;
        logic [7:0]  ev;
        logic [7:0]  dl;
        logic        ek;
        logic        dk;
        logic [15:0] cs;
        logic        last;
        int          s;
        wait_fall();
        if (!abort) begin
            if (pend) begin
                check_val("tx_data_o", tx_data_o, exp_data);
                check_val("tx_is_k_o", {14'h0, tx_is_k_o}, {14'h0, exp_k});
            end
            rand_byte(db);
            ready_i       = rdy;
            dbus_i        = db;
            seg_num_wr_i  = wr_num;
            seg_byte_wr_i = wr_byte;
            seg_waddr_i   = waddr;
            seg_data_i    = wdata;
            ev   = 8'h00;
            ek   = 1'b0;
            dl   = 8'h00;
            dk   = 1'b0;
            last = rdy && (widx == FRAME_WORDS - 1); // swap edge
            if (rdy) begin
                if (widx % 4 == 0) begin
                    ev = comma_code;
                    ek = 1'b1;
                end else if (widx % 7 == 0) begin
                    ev = beacon_code; // no K
                end
                s  = widx / 2;
                cs = rule_csum(act_num, act_mem);
                if (widx % 2 == 0) begin
                    dl = db; // bus byte on even words
                end else if (s == 0) begin
                    dl = start_code;
                    dk = 1'b1;
                end else if (s == 1) begin
                    dl = act_num;
                end else if (s <= SEG_BYTES + 1) begin
                    dl = act_mem[s - 2];
                end else if (s == SEG_BYTES + 2) begin
                    dl = stop_code;
                    dk = 1'b1;
                end else if (s == SEG_BYTES + 3) begin
                    dl = cs[15:8];
                end else if (s == SEG_BYTES + 4) begin
                    dl = cs[7:0];
                end
                widx = (widx + 1) % FRAME_WORDS;
            end else begin
                widx = 0; // link down, restart at word 0
            end
            exp_data = {ev, dl};
            exp_k    = {ek, dk};
            pend     = 1'b1;
            if (!rdy || last) begin
                act_num = stg_num; // old staging, before this write
                act_mem = stg_mem;
            end
            if (wr_num) begin
                stg_num = wdata;
            end
            if (wr_byte) begin
                stg_mem[waddr] = wdata;
            end
        end
    endtask

    // count words, the first SEG_BYTES+1 of them stage entry e when e >= 0
    task automatic run_words(input logic rdy, input int count, input int e);
        int i;
        if (e >= 0) begin
            lfsr = lfsr_seed_c + e;
        end
        for (i = 0; i < count; i++) begin
            if (e >= 0 && i == 0) begin
                step(rdy, 1'b1, 1'b0, 8'h00, tbl_num[e]);
            end else if (e >= 0 && i <= SEG_BYTES) begin
                step(rdy, 1'b0, 1'b1, 8'(i - 1), tbl_data[e][i - 1]);
            end else begin
                step(rdy, 1'b0, 1'b0, 8'h00, 8'h00);
            end
        end
    endtask

    initial begin
        int         e;
        int         i;
        logic [7:0] tmp [SEG_BYTES];
        arst_n_i      = 1'b0;
        ready_i       = 1'b0;
        dbus_i        = 8'h00;
        seg_byte_wr_i = 1'b0;
        seg_num_wr_i  = 1'b0;
        seg_waddr_i   = 8'h00;
        seg_data_i    = 8'h00;
        for (i = 0; i < SEG_BYTES; i++) begin
            stg_mem[i] = 8'h00;
            act_mem[i] = 8'h00;
        end
        fill_table();
        for (e = 0; e < n_entries; e++) begin
            for (i = 0; i < SEG_BYTES; i++) begin
                tmp[i] = tbl_data[e][i];
            end
            check_val("table checksum", rule_csum(tbl_num[e], tmp), tbl_csum[e]);
        end
        for (i = 0; i < 8; i++) begin
            wait_fall();
            check_val("tx_data_o", tx_data_o, 16'h0000); // held in reset
            check_val("tx_is_k_o", {14'h0, tx_is_k_o}, 16'h0000);
        end
        arst_n_i = 1'b1;
        run_words(1'b0, 4, -1);  // link down, idle
        run_words(1'b0, 20, 0);  // stage reference segment while down
        for (e = 0; e < n_entries; e++) begin
            run_words(1'b1, FRAME_WORDS, (e + 1 < n_entries) ? e + 1 : -1); // next one staged
        end
        run_words(1'b1, 24, 0);  // restage, then drop mid frame
        run_words(1'b0, 6, -1);
        run_words(1'b1, FRAME_WORDS + 8, -1); // restart shows the new segment
        run_words(1'b0, 2, -1);
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0 && !abort) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
tx_frame_pkg.sv
event_lane_gen.sv
segment_buffer.sv
segment_framer.sv
tx_frame_gen.sv
tb_tx_frame_gen.sv

// ==== Makefile ====
# Verilator build and run of the tx frame generator testbench

VERILATOR ?= verilator
TOP       ?= tb_tx_frame_gen
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG  := tests failed
PASS_MSG  := all tests passed
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result line, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
